//--- compile.f
+incdir+src
src/game_pkg.sv
src/shop_pkg.sv
src/shop_counter.sv
src/move_inventory.sv
src/fight_fsm.sv
src/game_top.sv
testbench/tb_clock.sv
testbench/game_chk.sv
testbench/game_tb.sv

//--- src/fight_fsm.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defines.svh"

module fight_fsm
    import game_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     turn,
    input  logic                     play_valid,
    input  logic                     start_round,
    input  action_t                  play_action,
    input  logic [`G_NUM_MOVES-1:0]  p1_stocked,
    input  logic [`G_NUM_MOVES-1:0]  p2_stocked,
    output phase_t                   phase,
    output logic [`G_HEALTH_W-1:0]   p1_health,
    output logic [`G_HEALTH_W-1:0]   p2_health,
    output logic [`G_POS_W-1:0]      p1_pos,
    output logic [`G_POS_W-1:0]      p2_pos,
    output winner_t                  winner,
    output logic [`G_MOVE_CNT_W-1:0] match_moves,
    output logic                     match_over,
    output logic                     p1_spend,
    output logic                     p2_spend,
    output logic                     err_no_inventory,
    output logic                     err_wrong_distance
);

    localparam logic [`G_HEALTH_W-1:0] START_HEALTH = `G_START_HEALTH;
    localparam logic [`G_HEALTH_W-1:0] KICK_DAMAGE = `G_KICK_DAMAGE;
    localparam logic [`G_HEALTH_W-1:0] PUNCH_DAMAGE = `G_PUNCH_DAMAGE;
    localparam logic [`G_POS_W-1:0] HOME_POS = `G_HOME_POS;
    localparam logic [`G_POS_W-1:0] MAX_POS = `G_MAX_POS;
    localparam logic [`G_POS_W:0] KICK_RANGE = `G_KICK_RANGE;
    localparam logic [`G_POS_W:0] PUNCH_RANGE = `G_PUNCH_RANGE;

    logic [`G_POS_W:0]      distance;
    logic [7:0]             stocked_ext;
    logic                   play_now;
    logic                   spend_ok;
    logic                   is_kick;
    logic                   is_punch;
    logic                   in_range;
    logic                   hit;
    logic [`G_HEALTH_W-1:0] damage;
    logic [`G_HEALTH_W-1:0] opp_health;
    logic                   raise;
    logic                   lower;
    logic [`G_POS_W-1:0]    act_pos;
    logic [`G_POS_W-1:0]    new_pos;

    assign distance = {1'b0, p1_pos} + {1'b0, p2_pos};

    // Padded to cover codes 5 to 7, which never count as stocked
    assign stocked_ext = {3'b000, (turn ? p2_stocked : p1_stocked)};

    assign play_now = (phase == phase_play) && play_valid && (play_action <= act_wait);
    assign spend_ok = play_now && stocked_ext[play_action];
    assign p1_spend = spend_ok && !turn;
    assign p2_spend = spend_ok && turn;

    assign is_kick    = (play_action == act_kick);
    assign is_punch   = (play_action == act_punch);
    assign in_range   = (is_kick && distance == KICK_RANGE) ||
                        (is_punch && distance == PUNCH_RANGE);
    assign hit        = spend_ok && in_range;
    assign damage     = is_kick ? KICK_DAMAGE : PUNCH_DAMAGE;
    assign opp_health = turn ? p1_health : p2_health;
    assign match_over = hit && (opp_health <= damage);

    // Player 2 faces the other way
    assign raise   = turn ? (play_action == act_right) : (play_action == act_left);
    assign lower   = turn ? (play_action == act_left) : (play_action == act_right);
    assign act_pos = turn ? p2_pos : p1_pos;

    always_comb begin
        new_pos = act_pos;
        if (raise && act_pos < MAX_POS)
            new_pos = act_pos + 1'b1;
        else if (lower && act_pos != '0)
            new_pos = act_pos - 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase              <= phase_shop;
            p1_health          <= START_HEALTH;
            p2_health          <= START_HEALTH;
            p1_pos             <= HOME_POS;
            p2_pos             <= HOME_POS;
            winner             <= win_none;
            match_moves        <= '0;
            err_no_inventory   <= 1'b0;
            err_wrong_distance <= 1'b0;
        end else if (match_over) begin
            phase              <= phase_shop;
            p1_health          <= START_HEALTH;
            p2_health          <= START_HEALTH;
            p1_pos             <= HOME_POS;
            p2_pos             <= HOME_POS;
            winner             <= turn ? win_p2 : win_p1;
            match_moves        <= match_moves + 1'b1;   // Lethal hit counts
            err_no_inventory   <= 1'b0;
            err_wrong_distance <= 1'b0;
        end else if (phase == phase_shop) begin
            if (start_round) begin
                phase       <= phase_play;
                winner      <= win_none;
                match_moves <= '0;
            end
        end else begin
            err_no_inventory   <= play_now && !spend_ok;
            err_wrong_distance <= spend_ok && (is_kick || is_punch) && !in_range;
            if (spend_ok) begin
                match_moves <= match_moves + 1'b1;
                if (turn)
                    p2_pos <= new_pos;
                else
                    p1_pos <= new_pos;
                if (hit) begin
                    if (turn)
                        p1_health <= p1_health - damage;
                    else
                        p2_health <= p2_health - damage;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// Credit and pricing
`define G_CREDIT_W       10
`define G_START_CREDIT   500
`define G_MULT_W         7

// Player state
`define G_HEALTH_W       2
`define G_START_HEALTH   3
`define G_POS_W          2
`define G_HOME_POS       2
`define G_MAX_POS        2

// Inventory
`define G_NUM_MOVES      5
`define G_MOVE_CNT_W     4

// Hits
`define G_KICK_DAMAGE    1
`define G_PUNCH_DAMAGE   2
`define G_KICK_RANGE     1   // Distance needed for a kick
`define G_PUNCH_RANGE    0

// Winner discount thresholds, in moves per match
`define G_TIER1_MOVES    6
`define G_TIER2_MOVES    9

`endif

//--- src/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef enum logic {
        phase_play = 1'b0,
        phase_shop = 1'b1
    } phase_t;

    // Codes 5 to 7 are not moves
    typedef enum logic [2:0] {
        act_kick  = 3'd0,
        act_punch = 3'd1,
        act_left  = 3'd2,
        act_right = 3'd3,
        act_wait  = 3'd4
    } action_t;

    typedef enum logic [1:0] {
        win_none = 2'd0,
        win_p1   = 2'd1,
        win_p2   = 2'd2
    } winner_t;

endpackage

`default_nettype wire

//--- src/game_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defines.svh"

module game_top
    import game_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   turn,
    input  logic                   play_valid,
    input  action_t                play_action,
    input  logic                   buy_valid_p1,
    input  action_t                buy_code_p1,
    input  logic                   buy_valid_p2,
    input  action_t                buy_code_p2,
    input  logic                   start_round,
    input  logic [`G_CREDIT_W-1:0] price0,
    input  logic [`G_CREDIT_W-1:0] price1,
    input  logic [`G_CREDIT_W-1:0] price2,
    input  logic [`G_CREDIT_W-1:0] price3,
    input  logic [`G_CREDIT_W-1:0] price4,
    output phase_t                 phase,
    output logic [`G_HEALTH_W-1:0] p1_health,
    output logic [`G_HEALTH_W-1:0] p2_health,
    output logic [`G_CREDIT_W-1:0] p1_credit,
    output logic [`G_CREDIT_W-1:0] p2_credit,
    output logic [`G_POS_W-1:0]    p1_pos,
    output logic [`G_POS_W-1:0]    p2_pos,
    output winner_t                winner,
    output logic                   purchase_success_p1,
    output logic                   err_invalid_action_p1,
    output logic                   err_credit_p1,
    output logic                   purchase_success_p2,
    output logic                   err_invalid_action_p2,
    output logic                   err_credit_p2,
    output logic                   err_no_inventory,
    output logic                   err_wrong_distance
);

    logic [`G_MOVE_CNT_W-1:0] match_moves;
    logic                     match_over;
    logic                     p1_spend;
    logic                     p2_spend;
    logic [`G_NUM_MOVES-1:0]  p1_grant;
    logic [`G_NUM_MOVES-1:0]  p2_grant;
    logic [`G_NUM_MOVES-1:0]  p1_stocked;
    logic [`G_NUM_MOVES-1:0]  p2_stocked;

    wire shop_open = (phase == phase_shop);
    wire p1_won    = (winner == win_p1);
    wire p2_won    = (winner == win_p2);

    shop_counter u_shop_p1 (
        .clk                (clk),
        .rst                (rst),
        .buy_valid          (buy_valid_p1),
        .buy_code           (buy_code_p1),
        .price0             (price0),
        .price1             (price1),
        .price2             (price2),
        .price3             (price3),
        .price4             (price4),
        .shop_open          (shop_open),
        .match_over         (match_over),
        .is_winner          (p1_won),
        .match_moves        (match_moves),
        .credit             (p1_credit),
        .buy_grant          (p1_grant),
        .purchase_success   (purchase_success_p1),
        .err_invalid_action (err_invalid_action_p1),
        .err_credit         (err_credit_p1)
    );

    shop_counter u_shop_p2 (
        .clk                (clk),
        .rst                (rst),
        .buy_valid          (buy_valid_p2),
        .buy_code           (buy_code_p2),
        .price0             (price0),
        .price1             (price1),
        .price2             (price2),
        .price3             (price3),
        .price4             (price4),
        .shop_open          (shop_open),
        .match_over         (match_over),
        .is_winner          (p2_won),
        .match_moves        (match_moves),
        .credit             (p2_credit),
        .buy_grant          (p2_grant),
        .purchase_success   (purchase_success_p2),
        .err_invalid_action (err_invalid_action_p2),
        .err_credit         (err_credit_p2)
    );

    // Both inventories see the play code, only the active one gets spend
    move_inventory u_inv_p1 (
        .clk        (clk),
        .rst        (rst),
        .buy_grant  (p1_grant),
        .spend      (p1_spend),
        .spend_code (play_action),
        .match_over (match_over),
        .stocked    (p1_stocked)
    );

    move_inventory u_inv_p2 (
        .clk        (clk),
        .rst        (rst),
        .buy_grant  (p2_grant),
        .spend      (p2_spend),
        .spend_code (play_action),
        .match_over (match_over),
        .stocked    (p2_stocked)
    );

    fight_fsm u_fight (
        .clk                (clk),
        .rst                (rst),
        .turn               (turn),
        .play_valid         (play_valid),
        .start_round        (start_round),
        .play_action        (play_action),
        .p1_stocked         (p1_stocked),
        .p2_stocked         (p2_stocked),
        .phase              (phase),
        .p1_health          (p1_health),
        .p2_health          (p2_health),
        .p1_pos             (p1_pos),
        .p2_pos             (p2_pos),
        .winner             (winner),
        .match_moves        (match_moves),
        .match_over         (match_over),
        .p1_spend           (p1_spend),
        .p2_spend           (p2_spend),
        .err_no_inventory   (err_no_inventory),
        .err_wrong_distance (err_wrong_distance)
    );

endmodule

`default_nettype wire

//--- src/move_inventory.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defines.svh"

module move_inventory
    import game_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`G_NUM_MOVES-1:0] buy_grant,
    input  logic                    spend,
    input  action_t                 spend_code,
    input  logic                    match_over,
    output logic [`G_NUM_MOVES-1:0] stocked
);

    // One counter per move kind, indexed by action code
    logic [`G_MOVE_CNT_W-1:0] count [`G_NUM_MOVES];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `G_NUM_MOVES; i++) begin
                count[i] <= '0;
            end
        end else if (match_over) begin
            for (int i = 0; i < `G_NUM_MOVES; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `G_NUM_MOVES; i++) begin
                if (buy_grant[i])
                    count[i] <= count[i] + 1'b1;
                else if (spend && spend_code == action_t'(i))
                    count[i] <= count[i] - 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `G_NUM_MOVES; i++) begin
            stocked[i] = (count[i] != '0);
        end
    end

endmodule

`default_nettype wire

//--- src/shop_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defines.svh"

module shop_counter
    import game_pkg::*, shop_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     buy_valid,
    input  action_t                  buy_code,
    input  logic [`G_CREDIT_W-1:0]   price0,
    input  logic [`G_CREDIT_W-1:0]   price1,
    input  logic [`G_CREDIT_W-1:0]   price2,
    input  logic [`G_CREDIT_W-1:0]   price3,
    input  logic [`G_CREDIT_W-1:0]   price4,
    input  logic                     shop_open,
    input  logic                     match_over,
    input  logic                     is_winner,
    input  logic [`G_MOVE_CNT_W-1:0] match_moves,
    output logic [`G_CREDIT_W-1:0]   credit,
    output logic [`G_NUM_MOVES-1:0]  buy_grant,
    output logic                     purchase_success,
    output logic                     err_invalid_action,
    output logic                     err_credit
);

    localparam int PROD_W = `G_CREDIT_W + `G_MULT_W;
    localparam logic [PROD_W-1:0] PERCENT = 100;
    localparam logic [`G_CREDIT_W-1:0] START_CREDIT = `G_START_CREDIT;
    localparam logic [`G_MULT_W-1:0] MULT_FULL = 100;
    localparam logic [`G_MULT_W-1:0] MULT_95 = 95;
    localparam logic [`G_MULT_W-1:0] MULT_90 = 90;
    localparam logic [`G_MULT_W-1:0] MULT_80 = 80;

    tier_t                   tier;
    buy_result_t             result;
    logic [`G_MULT_W-1:0]    mult;
    logic [`G_CREDIT_W-1:0]  list_price;
    logic [`G_CREDIT_W-1:0]  cost;
    logic [PROD_W-1:0]       product;
    logic [PROD_W-1:0]       scaled;

    // Faster wins earn a deeper discount
    always_comb begin
        if (!is_winner)
            tier = tier_full;
        else if (match_moves <= `G_TIER1_MOVES)
            tier = tier_80;
        else if (match_moves <= `G_TIER2_MOVES)
            tier = tier_90;
        else
            tier = tier_95;
    end

    always_comb begin
        case (tier)
            tier_95: mult = MULT_95;
            tier_90: mult = MULT_90;
            tier_80: mult = MULT_80;
            default: mult = MULT_FULL;
        endcase
    end

    always_comb begin
        case (buy_code)
            act_kick:  list_price = price0;
            act_punch: list_price = price1;
            act_left:  list_price = price2;
            act_right: list_price = price3;
            act_wait:  list_price = price4;
            default:   list_price = '0;
        endcase
    end

    assign product = list_price * mult;
    assign scaled  = product / PERCENT;   // Rounds down
    assign cost    = scaled[`G_CREDIT_W-1:0];

    always_comb begin
        result = buy_none;
        if (buy_valid && shop_open) begin
            if (buy_code > act_wait)
                result = buy_bad_code;
            else if (cost > credit)
                result = buy_no_credit;
            else
                result = buy_granted;
        end
    end

    always_comb begin
        buy_grant = '0;
        if (result == buy_granted)
            buy_grant[buy_code] = 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit             <= START_CREDIT;
            purchase_success   <= 1'b0;
            err_invalid_action <= 1'b0;
            err_credit         <= 1'b0;
        end else begin
            if (match_over)
                credit <= START_CREDIT;
            else if (result == buy_granted)
                credit <= credit - cost;
            purchase_success   <= (result == buy_granted);
            err_invalid_action <= (result == buy_bad_code);
            err_credit         <= (result == buy_no_credit);
        end
    end

endmodule

`default_nettype wire

//--- src/shop_pkg.sv
`default_nettype none

package shop_pkg;

    typedef enum logic [1:0] {
        tier_full,  // 100 %
        tier_95,
        tier_90,
        tier_80
    } tier_t;

    typedef enum logic [1:0] {
        buy_none,
        buy_granted,
        buy_bad_code,
        buy_no_credit
    } buy_result_t;

endpackage

`default_nettype wire

//--- testbench/game_chk.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defines.svh"

module game_chk
    import game_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input phase_t                 phase,
    input logic [`G_HEALTH_W-1:0] p1_health,
    input logic [`G_HEALTH_W-1:0] p2_health,
    input logic [`G_CREDIT_W-1:0] p1_credit,
    input logic [`G_CREDIT_W-1:0] p2_credit,
    input logic [`G_POS_W-1:0]    p1_pos,
    input logic [`G_POS_W-1:0]    p2_pos,
    input logic                   purchase_success_p1,
    input logic                   err_invalid_action_p1,
    input logic                   err_credit_p1,
    input logic                   purchase_success_p2,
    input logic                   err_invalid_action_p2,
    input logic                   err_credit_p2,
    input logic                   err_no_inventory,
    input logic                   err_wrong_distance
);

    // A refused purchase leaves credit alone
    a_shop1_refused_keeps_credit: assert property (@(posedge clk) disable iff (rst)
        (err_invalid_action_p1 || err_credit_p1) |-> (p1_credit == $past(p1_credit)))
        else $error("Shop 1 changed credit on a refused purchase");

    a_shop2_refused_keeps_credit: assert property (@(posedge clk) disable iff (rst)
        (err_invalid_action_p2 || err_credit_p2) |-> (p2_credit == $past(p2_credit)))
        else $error("Shop 2 changed credit on a refused purchase");

    a_quiet_in_shop: assert property (@(posedge clk) disable iff (rst)
        (phase == phase_shop) |-> !(err_no_inventory || err_wrong_distance))
        else $error("Play error flag high in the shop phase");

    // Lethal hit reloads health before it can reach zero
    a_health_alive: assert property (@(posedge clk) disable iff (rst)
        (p1_health != '0) && (p2_health != '0))
        else $error("Health reached zero without ending the match");

    a_pos_max: assert property (@(posedge clk) disable iff (rst)
        (p1_pos <= `G_MAX_POS) && (p2_pos <= `G_MAX_POS))
        else $error("Position above its upper limit");

endmodule

bind game_top game_chk u_chk (.*);

`default_nettype wire

//--- testbench/game_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "game_defines.svh"

module game_tb
    import game_pkg::*;
();

    localparam int MAX_ROWS = 32;
    localparam int DRIVE_DELAY = 2;

    typedef struct packed {
        logic       turn;
        logic       play_valid;
        logic [2:0] action;
        logic       bv1;
        logic [2:0] bc1;
        logic       bv2;
        logic [2:0] bc2;
        logic       start;
    } stim_t;

    // Outputs seen after the edge that samples the row
    typedef struct packed {
        logic       phase;
        logic [1:0] h1;
        logic [1:0] h2;
        logic [9:0] c1;
        logic [9:0] c2;
        logic [1:0] pos1;
        logic [1:0] pos2;
        logic [1:0] winner;
        logic [7:0] flags;   // ps1 ei1 ec1 ps2 ei2 ec2 eni ewd
    } expect_t;

    logic clk;
    logic rst;
    logic turn;
    logic play_valid;
    logic buy_valid_p1;
    logic buy_valid_p2;
    logic start_round;
    action_t play_action;
    action_t buy_code_p1;
    action_t buy_code_p2;
    logic [`G_CREDIT_W-1:0] price0, price1, price2, price3, price4;
    phase_t phase;
    winner_t winner;
    logic [`G_HEALTH_W-1:0] p1_health, p2_health;
    logic [`G_CREDIT_W-1:0] p1_credit, p2_credit;
    logic [`G_POS_W-1:0] p1_pos, p2_pos;
    logic purchase_success_p1, err_invalid_action_p1, err_credit_p1;
    logic purchase_success_p2, err_invalid_action_p2, err_credit_p2;
    logic err_no_inventory, err_wrong_distance;

    stim_t   stim [MAX_ROWS];
    expect_t expv [MAX_ROWS];
    string   names [MAX_ROWS];
    int      n_rows = 0;
    int      n_checks = 0;
    int      n_errors = 0;
    int      cycles = 0;
    int      cycle_limit = 0;

    // Reference model state
    int         m_price [5] = '{100, 150, 50, 50, 20};
    logic       m_shop;
    int         m_health [2];
    int         m_credit [2];
    int         m_pos [2];
    int         m_inv [2][5];
    int         m_winner;
    int         m_moves;
    logic [7:0] m_flags;

    tb_clock u_clock (.clk(clk));

    game_top UUT (.*);

    task add_row(input string name, input logic t, input logic pv, input int act,
                 input logic b1, input int c1, input logic b2, input int c2,
                 input logic st);
        names[n_rows] = name;
        stim[n_rows] = {t, pv, act[2:0], b1, c1[2:0], b2, c2[2:0], st};
        n_rows++;
    endtask

    function int discount_pct(input int p);
        if (m_winner != p + 1)
            return 100;
        if (m_moves <= 6)
            return 80;
        if (m_moves <= 9)
            return 90;
        return 95;
    endfunction

    task restore_players();
        for (int p = 0; p < 2; p++) begin
            m_health[p] = 3;
            m_credit[p] = 500;
            m_pos[p] = 2;
            for (int k = 0; k < 5; k++)
                m_inv[p][k] = 0;
        end
    endtask

    task model_step(input stim_t s, output expect_t e);
        int   code [2];
        int   cost [2];
        logic granted [2];
        int   act;
        int   me;
        int   base;
        int   dmg;
        logic over;
        code[0] = int'(s.bc1);
        code[1] = int'(s.bc2);
        act = int'(s.action);
        me = int'(s.turn);
        over = 1'b0;
        for (int p = 0; p < 2; p++) begin
            base = 7 - 3 * p;
            granted[p] = 1'b0;
            cost[p] = 0;
            m_flags[base -: 3] = 3'b000;
            if ((p == 0 ? s.bv1 : s.bv2) && m_shop) begin
                if (code[p] > 4) begin
                    m_flags[base - 1] = 1'b1;
                end else begin
                    cost[p] = m_price[code[p]] * discount_pct(p) / 100;
                    if (cost[p] > m_credit[p]) begin
                        m_flags[base - 2] = 1'b1;
                    end else begin
                        granted[p] = 1'b1;
                        m_flags[base] = 1'b1;
                    end
                end
            end
        end
        if (!m_shop) begin
            m_flags[1:0] = 2'b00;
            if (s.play_valid && act <= 4) begin
                if (m_inv[me][act] == 0) begin
                    m_flags[1] = 1'b1;
                end else begin
                    m_inv[me][act]--;
                    m_moves++;
                    if (act <= 1) begin
                        dmg = (act == 0) ? 1 : 2;
                        if (m_pos[0] + m_pos[1] != ((act == 0) ? 1 : 0))
                            m_flags[0] = 1'b1;
                        else if (m_health[1 - me] <= dmg)
                            over = 1'b1;
                        else
                            m_health[1 - me] -= dmg;
                    end else if (act != 4) begin
                        if ((act == 2) == (me == 0))   // Toward the high end
                            m_pos[me] = (m_pos[me] < 2) ? m_pos[me] + 1 : 2;
                        else
                            m_pos[me] = (m_pos[me] > 0) ? m_pos[me] - 1 : 0;
                    end
                end
            end
        end else if (s.start) begin
            m_shop = 1'b0;
            m_winner = 0;
            m_moves = 0;
        end
        if (over) begin
            m_shop = 1'b1;
            m_winner = me + 1;
            m_flags[1:0] = 2'b00;
            restore_players();
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (granted[p]) begin
                    m_credit[p] -= cost[p];
                    m_inv[p][code[p]]++;
                end
            end
        end
        e.phase = m_shop;
        e.h1 = m_health[0][1:0];
        e.h2 = m_health[1][1:0];
        e.c1 = m_credit[0][9:0];
        e.c2 = m_credit[1][9:0];
        e.pos1 = m_pos[0][1:0];
        e.pos2 = m_pos[1][1:0];
        e.winner = m_winner[1:0];
        e.flags = m_flags;
    endtask

    task check_value(input string test, input string field,
                     input logic [15:0] expected, input logic [15:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("** Error %s: %s expected %0d, actual %0d", test, field, expected, actual);
        end
    endtask

    task check_outputs(input int i);
        check_value(names[i], "phase", expv[i].phase, phase);
        check_value(names[i], "p1_health", expv[i].h1, p1_health);
        check_value(names[i], "p2_health", expv[i].h2, p2_health);
        check_value(names[i], "p1_credit", expv[i].c1, p1_credit);
        check_value(names[i], "p2_credit", expv[i].c2, p2_credit);
        check_value(names[i], "p1_pos", expv[i].pos1, p1_pos);
        check_value(names[i], "p2_pos", expv[i].pos2, p2_pos);
        check_value(names[i], "winner", expv[i].winner, winner);
        check_value(names[i], "flags", expv[i].flags,
                    {purchase_success_p1, err_invalid_action_p1, err_credit_p1,
                     purchase_success_p2, err_invalid_action_p2, err_credit_p2,
                     err_no_inventory, err_wrong_distance});
    endtask

    task apply_row(input int i);
        turn = stim[i].turn;
        play_valid = stim[i].play_valid;
        play_action = action_t'(stim[i].action);
        buy_valid_p1 = stim[i].bv1;
        buy_code_p1 = action_t'(stim[i].bc1);
        buy_valid_p2 = stim[i].bv2;
        buy_code_p2 = action_t'(stim[i].bc2);
        start_round = stim[i].start;
    endtask

    task build_table();
        add_row("reset_idle",          0, 0, 0,         0, 0,         0, 0,        0);
        add_row("buy_p1_kick",         0, 0, 0,         1, act_kick,  0, 0,        0);
        add_row("buy_p1_kick_again",   0, 0, 0,         1, act_kick,  0, 0,        0);
        add_row("buy_both_moves",      0, 0, 0,         1, act_right, 1, act_left, 0);
        add_row("buy_both_moves_again", 0, 0, 0,        1, act_right, 1, act_left, 0);
        add_row("buy_p1_punch",        0, 0, 0,         1, act_punch, 0, 0,        0);
        add_row("buy_p1_no_credit",    0, 0, 0,         1, act_kick,  0, 0,        0);
        add_row("buy_p2_bad_code",     0, 0, 0,         0, 0,         1, 6,        0);
        add_row("start_round",         0, 0, 0,         0, 0,         0, 0,        1);
        add_row("play_p2_unbought",    1, 1, act_kick,  0, 0,         0, 0,        0);
        add_row("play_p1_far_kick",    0, 1, act_kick,  0, 0,         0, 0,        0);
        add_row("play_buy_ignored",    0, 0, 0,         1, act_wait,  1, act_wait, 0);
        add_row("play_p1_right",       0, 1, act_right, 0, 0,         0, 0,        0);
        add_row("play_p1_right_again", 0, 1, act_right, 0, 0,         0, 0,        0);
        add_row("play_p2_left",        1, 1, act_left,  0, 0,         0, 0,        0);
        add_row("play_p1_kick_hit",    0, 1, act_kick,  0, 0,         0, 0,        0);
        add_row("play_p2_left_again",  1, 1, act_left,  0, 0,         0, 0,        0);
        add_row("play_p1_punch_lethal", 0, 1, act_punch, 0, 0,        0, 0,        0);
        add_row("shop_discount",       0, 0, 0,         1, act_punch, 1, act_punch, 0);
        add_row("shop_idle",           0, 0, 0,         0, 0,         0, 0,        0);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout: table not finished within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        turn = 1'b0;
        play_valid = 1'b0;
        play_action = act_kick;
        buy_valid_p1 = 1'b0;
        buy_code_p1 = act_kick;
        buy_valid_p2 = 1'b0;
        buy_code_p2 = act_kick;
        start_round = 1'b0;
        price0 = 10'd100;
        price1 = 10'd150;
        price2 = 10'd50;
        price3 = 10'd50;
        price4 = 10'd20;
        build_table();
        m_shop = 1'b1;
        m_winner = 0;
        m_moves = 0;
        m_flags = '0;
        restore_players();
        for (int i = 0; i < n_rows; i++)
            model_step(stim[i], expv[i]);
        cycle_limit = n_rows + 20;
        repeat (2) @(posedge clk);
        #(DRIVE_DELAY) rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            if (i > 0)
                check_outputs(i - 1);
            apply_row(i);
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        check_outputs(n_rows - 1);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire
